/* hw/isa_pkg.sv */
package isa_pkg;

    localparam int op_w       = 6;
    localparam int fn_w       = 6;
    localparam int reg_addr_w = 5;
    localparam int word_w     = 32;

    localparam logic [reg_addr_w-1:0] ra_reg = 5'd31; // link register for jal.

    // primary opcodes, instruction bits 31:26.
    localparam logic [op_w-1:0] op_special = 6'h00;
    localparam logic [op_w-1:0] op_j       = 6'h02;
    localparam logic [op_w-1:0] op_jal     = 6'h03;
    localparam logic [op_w-1:0] op_beq     = 6'h04;
    localparam logic [op_w-1:0] op_bne     = 6'h05;
    localparam logic [op_w-1:0] op_blez    = 6'h06;
    localparam logic [op_w-1:0] op_bgtz    = 6'h07;
    localparam logic [op_w-1:0] op_addi    = 6'h08;
    localparam logic [op_w-1:0] op_ori     = 6'h0d;
    localparam logic [op_w-1:0] op_lui     = 6'h0f;
    localparam logic [op_w-1:0] op_lb      = 6'h20;
    localparam logic [op_w-1:0] op_lw      = 6'h23;
    localparam logic [op_w-1:0] op_sb      = 6'h28;
    localparam logic [op_w-1:0] op_sw      = 6'h2b;

    // funct codes under op_special, bits 5:0.
    localparam logic [fn_w-1:0] fn_sll  = 6'h00;
    localparam logic [fn_w-1:0] fn_jr   = 6'h08;
    localparam logic [fn_w-1:0] fn_addu = 6'h21;
    localparam logic [fn_w-1:0] fn_subu = 6'h23;
    localparam logic [fn_w-1:0] fn_and  = 6'h24;
    localparam logic [fn_w-1:0] fn_or   = 6'h25;
    localparam logic [fn_w-1:0] fn_slt  = 6'h2a;

endpackage

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    // alu operation.
    localparam logic [4:0] alu_add = 5'd0;
    localparam logic [4:0] alu_sub = 5'd1;
    localparam logic [4:0] alu_and = 5'd2;
    localparam logic [4:0] alu_or  = 5'd3;
    localparam logic [4:0] alu_slt = 5'd4;
    localparam logic [4:0] alu_sll = 5'd5;
    localparam logic [4:0] alu_lui = 5'd6; // passes operand b.

    localparam logic [2:0] npc_seq    = 3'd0;
    localparam logic [2:0] npc_branch = 3'd1; // taken only if branch_true.
    localparam logic [2:0] npc_jump   = 3'd2;
    localparam logic [2:0] npc_jr     = 3'd3;

    localparam logic [3:0] cmp_never = 4'd0;
    localparam logic [3:0] cmp_eq    = 4'd1;
    localparam logic [3:0] cmp_ne    = 4'd2;
    localparam logic [3:0] cmp_lez   = 4'd3;
    localparam logic [3:0] cmp_gtz   = 4'd4;

    localparam logic [1:0] ext_zero  = 2'd0;
    localparam logic [1:0] ext_sign  = 2'd1;
    localparam logic [1:0] ext_upper = 2'd2;

    localparam logic [1:0] wr_rt = 2'd0;
    localparam logic [1:0] wr_rd = 2'd1;
    localparam logic [1:0] wr_ra = 2'd2;

    localparam logic [1:0] wd_alu = 2'd0;
    localparam logic [1:0] wd_mem = 2'd1;
    localparam logic [1:0] wd_pc8 = 2'd2;

    localparam logic [1:0] asel_rs    = 2'd0;
    localparam logic [1:0] asel_shamt = 2'd1;
    localparam logic [1:0] bsel_rt    = 2'd0;
    localparam logic [1:0] bsel_imm   = 2'd1;

    localparam logic [1:0] mem_word = 2'd0;
    localparam logic [1:0] mem_byte = 2'd1;

    localparam logic [1:0] fwd_rf    = 2'd0;
    localparam logic [1:0] fwd_alu_m = 2'd1;
    localparam logic [1:0] fwd_pc8_m = 2'd2;

    localparam logic [2:0] t_none = 3'd7; // operand unused or no result.

endpackage

/* hw/controller.sv */
module controller (
    input  logic [isa_pkg::word_w-1:0] command,
    output logic       rfwe_d,
    output logic       dmwe_d,
    output logic [1:0] wr_sel,
    output logic [1:0] wdsel_d,
    output logic [1:0] ext_op,
    output logic [1:0] asel_d,
    output logic [1:0] bsel_d,
    output logic [1:0] dmtype_d,
    output logic [2:0] npcop,
    output logic [2:0] tuse_rs,
    output logic [2:0] tuse_rt,
    output logic [2:0] tnew_d,
    output logic [3:0] cmp_op,
    output logic [4:0] aluop_d
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [op_w-1:0] opcode;
    logic [fn_w-1:0] funct;

    assign opcode = command[31:26];
    assign funct  = command[5:0];

    always_comb begin
        rfwe_d   = 1'b0; // defaults describe a nop.
        dmwe_d   = 1'b0;
        wr_sel   = wr_rt;
        wdsel_d  = wd_alu;
        ext_op   = ext_zero;
        asel_d   = asel_rs;
        bsel_d   = bsel_rt;
        dmtype_d = mem_word;
        npcop    = npc_seq;
        tuse_rs  = t_none;
        tuse_rt  = t_none;
        tnew_d   = t_none;
        cmp_op   = cmp_never;
        aluop_d  = alu_add;
        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu, fn_subu, fn_and, fn_or, fn_slt: begin
                        rfwe_d  = 1'b1;
                        wr_sel  = wr_rd;
                        tuse_rs = 3'd1;
                        tuse_rt = 3'd1;
                        tnew_d  = 3'd1;
                        case (funct)
                            fn_subu: aluop_d = alu_sub;
                            fn_and:  aluop_d = alu_and;
                            fn_or:   aluop_d = alu_or;
                            fn_slt:  aluop_d = alu_slt;
                            default: aluop_d = alu_add;
                        endcase
                    end
                    fn_sll: begin
                        rfwe_d  = 1'b1;
                        wr_sel  = wr_rd;
                        asel_d  = asel_shamt;
                        aluop_d = alu_sll;
                        tuse_rt = 3'd1;
                        tnew_d  = 3'd1;
                    end
                    fn_jr: begin
                        npcop   = npc_jr;
                        tuse_rs = 3'd0; // target needed in decode.
                    end
                    default: ;
                endcase
            end
            op_ori, op_addi, op_lui: begin
                rfwe_d  = 1'b1;
                bsel_d  = bsel_imm;
                tnew_d  = 3'd1;
                tuse_rs = (opcode == op_lui) ? t_none : 3'd1;
                ext_op  = (opcode == op_ori) ? ext_zero :
                          (opcode == op_addi) ? ext_sign : ext_upper;
                aluop_d = (opcode == op_ori) ? alu_or :
                          (opcode == op_addi) ? alu_add : alu_lui;
            end
            op_lw, op_lb: begin
                rfwe_d   = 1'b1;
                wdsel_d  = wd_mem;
                ext_op   = ext_sign;
                bsel_d   = bsel_imm;
                dmtype_d = (opcode == op_lb) ? mem_byte : mem_word;
                tuse_rs  = 3'd1;
                tnew_d   = 3'd2; // data arrives after the memory stage.
            end
            op_sw, op_sb: begin
                dmwe_d   = 1'b1;
                ext_op   = ext_sign;
                bsel_d   = bsel_imm;
                dmtype_d = (opcode == op_sb) ? mem_byte : mem_word;
                tuse_rs  = 3'd1;
                tuse_rt  = 3'd2; // store data only needed in memory.
            end
            op_beq, op_bne: begin
                npcop   = npc_branch;
                cmp_op  = (opcode == op_beq) ? cmp_eq : cmp_ne;
                tuse_rs = 3'd0;
                tuse_rt = 3'd0;
            end
            op_blez, op_bgtz: begin
                npcop   = npc_branch;
                cmp_op  = (opcode == op_blez) ? cmp_lez : cmp_gtz;
                tuse_rs = 3'd0;
            end
            op_j: npcop = npc_jump;
            op_jal: begin
                npcop   = npc_jump;
                rfwe_d  = 1'b1;
                wr_sel  = wr_ra;
                wdsel_d = wd_pc8;
                tnew_d  = 3'd0; // pc8 is ready in decode.
            end
            default: ;
        endcase
    end

endmodule

/* hw/reg_file.sv */
module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  a1,
    input  logic [4:0]  a2,
    input  logic [4:0]  a3,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];
    logic        wr_en;

    assign wr_en = we && (a3 != 5'd0); // $zero is never written.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[a3] <= wd;
        end
    end

    // same-cycle write shows up on the read ports.
    assign rd1 = (wr_en && a3 == a1) ? wd : regs[a1];
    assign rd2 = (wr_en && a3 == a2) ? wd : regs[a2];

    a_zero_reg: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

/* hw/branch_cmp.sv */
module branch_cmp (
    input  logic [31:0] cmp_a,
    input  logic [31:0] cmp_b,
    input  logic [3:0]  cmp_op,
    output logic        branch_true
);
    import ctrl_pkg::*;

    logic signed [31:0] a_s;

    assign a_s = cmp_a;

    always_comb begin
        case (cmp_op)
            cmp_eq:  branch_true = (cmp_a == cmp_b);
            cmp_ne:  branch_true = (cmp_a != cmp_b);
            cmp_lez: branch_true = (a_s <= 0); // signed test against zero.
            cmp_gtz: branch_true = (a_s > 0);
            default: branch_true = 1'b0;
        endcase
    end

endmodule

/* hw/next_pc.sv */
module next_pc (
    input  logic [31:0] command_addr,
    input  logic [31:0] command,
    input  logic [31:0] rs_val,
    output logic [31:0] pc_b,
    output logic [31:0] pc_j,
    output logic [31:0] pc_jr,
    output logic [31:0] pc8
);

    logic [31:0] pc4;
    logic [31:0] offset;

    assign pc4    = command_addr + 32'd4;
    assign offset = {{14{command[15]}}, command[15:0], 2'b00}; // word offset.

    assign pc_b  = pc4 + offset;
    assign pc_j  = {pc4[31:28], command[25:0], 2'b00}; // stays in the 256 MB region.
    assign pc_jr = rs_val;
    assign pc8   = command_addr + 32'd8; // return address past the delay slot.

endmodule

/* hw/decode_stage.sv */
module decode_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  fwd_cmp_a_d,
    input  logic [1:0]  fwd_cmp_b_d,
    input  logic [31:0] command_d,
    input  logic [31:0] command_addr_d,
    input  logic        rfwe_w,
    input  logic [4:0]  write_addr_w,
    input  logic [31:0] res_w,
    input  logic [31:0] pc8_m,
    input  logic [31:0] alu_res_m,
    output logic        branch_true,
    output logic [31:0] ext_res,
    output logic [31:0] rf_rd1_d,
    output logic [31:0] rf_rd2_d,
    output logic [4:0]  read1_addr_d,
    output logic [4:0]  read2_addr_d,
    output logic [4:0]  write_addr_d,
    output logic        rfwe_d,
    output logic        dmwe_d,
    output logic [1:0]  wdsel_d,
    output logic [1:0]  asel_d,
    output logic [1:0]  bsel_d,
    output logic [1:0]  dmtype_d,
    output logic [2:0]  npcop,
    output logic [2:0]  tuse_rs,
    output logic [2:0]  tuse_rt,
    output logic [2:0]  tnew_d,
    output logic [4:0]  aluop_d,
    output logic [31:0] pc_b_d,
    output logic [31:0] pc_j_d,
    output logic [31:0] pc_jr_d,
    output logic [31:0] pc8_d
);
    import ctrl_pkg::*;

    logic [1:0]  wr_sel;
    logic [1:0]  ext_op;
    logic [3:0]  cmp_op;
    logic [31:0] rf_rd1_raw;
    logic [31:0] rf_rd2_raw;
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    logic [15:0] imm;

    assign read1_addr_d = command_d[25:21];
    assign read2_addr_d = command_d[20:16];
    assign imm          = command_d[15:0];

    always_comb begin
        case (wr_sel)
            wr_rt:   write_addr_d = command_d[20:16];
            wr_rd:   write_addr_d = command_d[15:11];
            wr_ra:   write_addr_d = '1; // $ra.
            default: write_addr_d = '0;
        endcase
    end

    always_comb begin
        case (ext_op)
            ext_sign:  ext_res = {{16{imm[15]}}, imm};
            ext_upper: ext_res = {imm, 16'h0000};
            default:   ext_res = {16'h0000, imm};
        endcase
    end

    // forwarding into the comparator operands.
    always_comb begin
        case (fwd_cmp_a_d)
            fwd_rf:    cmp_a = rf_rd1_raw;
            fwd_alu_m: cmp_a = alu_res_m;
            fwd_pc8_m: cmp_a = pc8_m;
            default:   cmp_a = '1;
        endcase
        case (fwd_cmp_b_d)
            fwd_rf:    cmp_b = rf_rd2_raw;
            fwd_alu_m: cmp_b = alu_res_m;
            fwd_pc8_m: cmp_b = pc8_m;
            default:   cmp_b = '1;
        endcase
    end

    assign rf_rd1_d = cmp_a;
    assign rf_rd2_d = cmp_b;

    controller u_controller (
        .command  (command_d),
        .rfwe_d   (rfwe_d),
        .dmwe_d   (dmwe_d),
        .wr_sel   (wr_sel),
        .wdsel_d  (wdsel_d),
        .ext_op   (ext_op),
        .asel_d   (asel_d),
        .bsel_d   (bsel_d),
        .dmtype_d (dmtype_d),
        .npcop    (npcop),
        .tuse_rs  (tuse_rs),
        .tuse_rt  (tuse_rt),
        .tnew_d   (tnew_d),
        .cmp_op   (cmp_op),
        .aluop_d  (aluop_d)
    );

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .a1  (read1_addr_d),
        .a2  (read2_addr_d),
        .a3  (write_addr_w),
        .we  (rfwe_w),
        .wd  (res_w),
        .rd1 (rf_rd1_raw),
        .rd2 (rf_rd2_raw)
    );

    branch_cmp u_branch_cmp (
        .cmp_a       (cmp_a),
        .cmp_b       (cmp_b),
        .cmp_op      (cmp_op),
        .branch_true (branch_true)
    );

    next_pc u_next_pc (
        .command_addr (command_addr_d),
        .command      (command_d),
        .rs_val       (cmp_a),
        .pc_b         (pc_b_d),
        .pc_j         (pc_j_d),
        .pc_jr        (pc_jr_d),
        .pc8          (pc8_d)
    );

    // the hazard unit never produces the unused select code.
    a_fwd_legal: assert property (@(posedge clk) disable iff (rst)
        fwd_cmp_a_d != 2'd3 && fwd_cmp_b_d != 2'd3);

endmodule

/* bench/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time half_period = 10ns;
    localparam int  reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* bench/decode_tb.sv */
module decode_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam string case_file = "bench/decode_cases.txt";
    localparam time   settle = 9ns; // just before the next rising edge.

    logic        clk;
    logic        rst;
    logic [1:0]  fwd_cmp_a_d;
    logic [1:0]  fwd_cmp_b_d;
    logic [31:0] command_d;
    logic [31:0] command_addr_d;
    logic        rfwe_w;
    logic [4:0]  write_addr_w;
    logic [31:0] res_w;
    logic [31:0] pc8_m;
    logic [31:0] alu_res_m;
    logic        branch_true;
    logic [31:0] ext_res;
    logic [31:0] rf_rd1_d;
    logic [31:0] rf_rd2_d;
    logic [4:0]  read1_addr_d;
    logic [4:0]  read2_addr_d;
    logic [4:0]  write_addr_d;
    logic        rfwe_d;
    logic        dmwe_d;
    logic [1:0]  wdsel_d;
    logic [1:0]  asel_d;
    logic [1:0]  bsel_d;
    logic [1:0]  dmtype_d;
    logic [2:0]  npcop;
    logic [2:0]  tuse_rs;
    logic [2:0]  tuse_rt;
    logic [2:0]  tnew_d;
    logic [4:0]  aluop_d;
    logic [31:0] pc_b_d;
    logic [31:0] pc_j_d;
    logic [31:0] pc_jr_d;
    logic [31:0] pc8_d;

    integer seed;
    integer fd;
    int     n_cases;
    string  fields [14]; // decode line columns after the case name.

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    decode_stage dut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // reference control word, packed as
    // rfwe, dmwe, wdsel, asel, bsel, dmtype, tuse_rs, tuse_rt, aluop.
    function automatic logic [20:0] expected_control(input logic [31:0] instr);
        logic [20:0] c;
        c = {2'b00, wd_alu, asel_rs, bsel_rt, mem_word, t_none, t_none, alu_add}; // nop.
        if (instr[31:26] == op_special) begin
            case (instr[5:0])
                fn_addu: c = {2'b10, wd_alu, asel_rs, bsel_rt, mem_word, 3'd1, 3'd1, alu_add};
                fn_subu: c = {2'b10, wd_alu, asel_rs, bsel_rt, mem_word, 3'd1, 3'd1, alu_sub};
                fn_and:  c = {2'b10, wd_alu, asel_rs, bsel_rt, mem_word, 3'd1, 3'd1, alu_and};
                fn_or:   c = {2'b10, wd_alu, asel_rs, bsel_rt, mem_word, 3'd1, 3'd1, alu_or};
                fn_slt:  c = {2'b10, wd_alu, asel_rs, bsel_rt, mem_word, 3'd1, 3'd1, alu_slt};
                fn_sll:  c = {2'b10, wd_alu, asel_shamt, bsel_rt, mem_word, t_none, 3'd1, alu_sll};
                fn_jr:   c = {2'b00, wd_alu, asel_rs, bsel_rt, mem_word, 3'd0, t_none, alu_add};
                default: ;
            endcase
        end else begin
            case (instr[31:26])
                op_ori:  c = {2'b10, wd_alu, asel_rs, bsel_imm, mem_word, 3'd1, t_none, alu_or};
                op_addi: c = {2'b10, wd_alu, asel_rs, bsel_imm, mem_word, 3'd1, t_none, alu_add};
                op_lui:  c = {2'b10, wd_alu, asel_rs, bsel_imm, mem_word, t_none, t_none, alu_lui};
                op_lw:   c = {2'b10, wd_mem, asel_rs, bsel_imm, mem_word, 3'd1, t_none, alu_add};
                op_lb:   c = {2'b10, wd_mem, asel_rs, bsel_imm, mem_byte, 3'd1, t_none, alu_add};
                op_sw:   c = {2'b01, wd_alu, asel_rs, bsel_imm, mem_word, 3'd1, 3'd2, alu_add};
                op_sb:   c = {2'b01, wd_alu, asel_rs, bsel_imm, mem_byte, 3'd1, 3'd2, alu_add};
                op_beq,
                op_bne:  c = {2'b00, wd_alu, asel_rs, bsel_rt, mem_word, 3'd0, 3'd0, alu_add};
                op_blez,
                op_bgtz: c = {2'b00, wd_alu, asel_rs, bsel_rt, mem_word, 3'd0, t_none, alu_add};
                op_jal:  c = {2'b10, wd_pc8, asel_rs, bsel_rt, mem_word, t_none, t_none, alu_add};
                default: ;
            endcase
        end
        return c;
    endfunction

    task automatic read_field(input string text, input string name, output bit given,
                              output logic [31:0] value);
        value = '0;
        given = 1'b0;
        if (text != "-") begin
            if ($sscanf(text, "%h", value) != 1) begin
                abort_run($sformatf("case %s has a field that is not hex: %s", name, text));
            end
            given = 1'b1;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                abort_run("reset was not released within 100 cycles");
            end
        end while (rst !== 1'b0);
    endtask

    // every register reads zero after reset, rs and rt swept in opposite order.
    task automatic sweep_reset_zero();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            command_d = {op_special, 5'(i), 5'(31 - i), 10'd0, fn_addu};
            #settle;
            check_value($sformatf("reset_read_r%0d.rd1", i), '0, rf_rd1_d);
            check_value($sformatf("reset_read_r%0d.rd2", i), '0, rf_rd2_d);
        end
    endtask

    // forward selects 1 and 2 on both operands, with distinct nonzero stage values.
    task automatic sweep_forward();
        logic [31:0] alu_v;
        logic [31:0] pc8_v;
        for (int s = 1; s < 3; s++) begin
            alu_v      = $random(seed);
            alu_v[1:0] = 2'b01; // nonzero, and so is its inverse.
            pc8_v      = ~alu_v;
            @(negedge clk);
            command_d   = {op_beq, 5'd0, 5'd0, 16'd0}; // both ports read $zero.
            fwd_cmp_a_d = 2'(s);
            fwd_cmp_b_d = 2'(3 - s);
            alu_res_m   = alu_v;
            pc8_m       = pc8_v;
            #settle;
            check_value($sformatf("fwd_a_sel%0d", s), (s == 1) ? alu_v : pc8_v, rf_rd1_d);
            check_value($sformatf("fwd_b_sel%0d", 3 - s), (s == 1) ? pc8_v : alu_v, rf_rd2_d);
        end
    endtask

    task automatic run_write(input string name, input logic [4:0] addr, input logic [31:0] value);
        logic [31:0] expected;
        @(negedge clk);
        rfwe_w         = 1'b1;
        write_addr_w   = addr;
        res_w          = value;
        command_d      = {op_special, addr, addr, 10'd0, fn_addu};
        command_addr_d = '0;
        fwd_cmp_a_d    = fwd_rf;
        fwd_cmp_b_d    = fwd_rf;
        pc8_m          = $random(seed);
        alu_res_m      = $random(seed);
        expected       = (addr == 5'd0) ? '0 : value; // $zero ignores writes.
        #settle;
        check_value({name, ".rd1"}, expected, rf_rd1_d);
        check_value({name, ".rd2"}, expected, rf_rd2_d);
    endtask

    task automatic run_decode(input string name);
        logic [31:0] v [14];
        bit          given [14];
        logic [31:0] target;
        for (int i = 0; i < 14; i++) begin
            read_field(fields[i], name, given[i], v[i]);
        end
        for (int i = 0; i < 4; i++) begin
            if (!given[i]) begin
                abort_run($sformatf("case %s lacks its instruction, address or selects", name));
            end
        end
        @(negedge clk);
        rfwe_w         = 1'b0;
        write_addr_w   = '0;
        res_w          = '0;
        command_d      = v[0];
        command_addr_d = v[1];
        fwd_cmp_a_d    = v[2][1:0];
        fwd_cmp_b_d    = v[3][1:0];
        pc8_m          = given[4] ? v[4] : $random(seed);
        alu_res_m      = given[5] ? v[5] : $random(seed);
        #settle;
        if (given[6]) check_value({name, ".branch_true"}, v[6], {31'd0, branch_true});
        if (given[7]) check_value({name, ".write_addr_d"}, v[7], {27'd0, write_addr_d});
        if (given[8]) check_value({name, ".ext_res"}, v[8], ext_res);
        if (given[9]) check_value({name, ".rf_rd1_d"}, v[9], rf_rd1_d);
        if (given[10]) check_value({name, ".rf_rd2_d"}, v[10], rf_rd2_d);
        if (given[11]) check_value({name, ".npcop"}, v[11], {29'd0, npcop});
        if (given[12]) check_value({name, ".tnew_d"}, v[12], {29'd0, tnew_d});
        case (v[11][2:0])
            npc_branch: target = pc_b_d;
            npc_jump:   target = pc_j_d;
            npc_jr:     target = pc_jr_d;
            default:    target = pc8_d;
        endcase
        if (given[13]) check_value({name, ".target"}, v[13], target);
        check_value({name, ".pc8_d"}, v[1] + 32'd8, pc8_d);
        check_value({name, ".read1_addr_d"}, {27'd0, v[0][25:21]}, {27'd0, read1_addr_d});
        check_value({name, ".read2_addr_d"}, {27'd0, v[0][20:16]}, {27'd0, read2_addr_d});
        check_value({name, ".control"}, {11'd0, expected_control(v[0])},
                    {11'd0, rfwe_d, dmwe_d, wdsel_d, asel_d, bsel_d, dmtype_d, tuse_rs,
                     tuse_rt, aluop_d});
    endtask

    initial begin
        string       kind;
        string       name;
        string       rest;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        int          got;
        seed           = 21132;
        n_cases        = 0;
        fwd_cmp_a_d    = fwd_rf;
        fwd_cmp_b_d    = fwd_rf;
        command_d      = '0;
        command_addr_d = '0;
        rfwe_w         = 1'b0;
        write_addr_w   = '0;
        res_w          = '0;
        pc8_m          = '0;
        alu_res_m      = '0;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            abort_run($sformatf("cannot open the case file %s", case_file));
        end
        wait_reset_release();
        sweep_reset_zero();
        sweep_forward();
        while (!$feof(fd)) begin
            got = $fscanf(fd, "%s", kind);
            if (got != 1) break;
            if (kind.getc(0) == "#") begin
                got = $fgets(rest, fd); // comment line.
            end else if (kind == "w") begin
                got = $fscanf(fd, "%s %h %h", name, addr_v, data_v);
                if (got != 3) abort_run("a write line in the case file is malformed");
                run_write(name, addr_v[4:0], data_v);
                n_cases++;
            end else if (kind == "d") begin
                got = $fscanf(fd, "%s %s %s %s %s %s %s %s %s %s %s %s %s %s %s", name,
                              fields[0], fields[1], fields[2], fields[3], fields[4],
                              fields[5], fields[6], fields[7], fields[8], fields[9],
                              fields[10], fields[11], fields[12], fields[13]);
                if (got != 15) abort_run("a decode line in the case file is malformed");
                run_decode(name);
                n_cases++;
            end else begin
                abort_run($sformatf("unknown line kind %s in the case file", kind));
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            abort_run("the case file holds no cases");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* bench/decode_cases.txt */
# w name reg value | d name instr pc fwd_a fwd_b pc8_m alu_res_m then expected:
# branch waddr ext rd1 rd2 npcop tnew target; '-' is a random input or an unchecked value
w zero_write 00 deadbeef
w set_r1 01 00000005
w set_r2 02 fffffff0
w set_r3 03 00000005
w set_r5 05 00400300
d addu_read 00223021 00400000 0 0 - - 0 06 - 00000005 fffffff0 0 1 00400008
d beq_fwd_alu 10230004 00400010 1 0 - 00000007 0 03 - 00000007 00000005 1 7 00400024
d beq_taken 1023fffe 00400020 0 0 - - 1 03 - 00000005 00000005 1 7 0040001c
d bne_fwd_pc8 14410008 00400030 2 1 00400100 00400100 0 01 - 00400100 00400100 1 7 00400054
d blez_neg 18400003 00400050 0 0 - - 1 00 - fffffff0 00000000 1 7 00400060
d blez_zero 18000003 00400070 0 0 - - 1 00 - 00000000 00000000 1 7 00400080
d bgtz_pos 1c200003 00400080 0 0 - - 1 00 - 00000005 00000000 1 7 00400090
d bgtz_min 1c200003 004000a0 1 0 - 80000000 0 00 - 80000000 00000000 1 7 004000b0
d ori_zext 34278001 004000b0 0 0 - - 0 07 00008001 00000005 00000000 0 1 004000b8
d addi_sext 2028fffc 004000c0 0 0 - - 0 08 fffffffc 00000005 00000000 0 1 004000c8
d lui_upper 3c091234 004000d0 0 0 - - 0 09 12340000 00000000 00000000 0 1 004000d8
d lw_sext 8c2afff8 004000e0 0 0 - - 0 0a fffffff8 00000005 00000000 0 2 004000e8
d sw_sext ac230010 004000f0 0 0 - - 0 03 00000010 00000005 00000005 0 7 004000f8
d slt_rd 0041582a 00400100 0 0 - - 0 0b - fffffff0 00000005 0 1 00400108
d j_region 08100040 9ffffffc 0 0 - - - - - - - 2 7 a0400100
d jal_link 0c100080 00400120 0 0 - - - 1f - - - 2 0 00400200
d jr_reg 00a00008 00400130 0 0 - - - - - 00400300 - 3 7 00400300
d jr_fwd 00a00008 00400140 1 0 - 00401000 - - - 00401000 - 3 7 00401000

/* list.f */
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/controller.sv
hw/reg_file.sv
hw/branch_cmp.sv
hw/next_pc.sv
hw/decode_stage.sv
bench/clock_gen.sv
bench/decode_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/controller.sv
      - hw/reg_file.sv
      - hw/branch_cmp.sv
      - hw/next_pc.sv
      - hw/decode_stage.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/decode_tb.sv
